/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;
    localparam int OPC_W     = 3;
    localparam int COND_W    = 3;  // condition reuses the rX field
    localparam int IMM_W     = 9;
    localparam int KIND_W    = 3;

    // opcode field, bits 15..13
    localparam logic [OPC_W-1:0] OPC_MV  = 3'b000;
    localparam logic [OPC_W-1:0] OPC_B   = 3'b001;
    localparam logic [OPC_W-1:0] OPC_ADD = 3'b010;
    localparam logic [OPC_W-1:0] OPC_SUB = 3'b011;
    localparam logic [OPC_W-1:0] OPC_LD  = 3'b100;
    localparam logic [OPC_W-1:0] OPC_ST  = 3'b101;
    localparam logic [OPC_W-1:0] OPC_CMP = 3'b111;

    localparam logic [COND_W-1:0] COND_NONE = 3'd0;
    localparam logic [COND_W-1:0] COND_EQ   = 3'd1;
    localparam logic [COND_W-1:0] COND_NE   = 3'd2;
    localparam logic [COND_W-1:0] COND_CC   = 3'd3;
    localparam logic [COND_W-1:0] COND_CS   = 3'd4;
    localparam logic [COND_W-1:0] COND_PL   = 3'd5;
    localparam logic [COND_W-1:0] COND_MI   = 3'd6;

    // operation kind carried down the pipe
    localparam logic [KIND_W-1:0] KIND_BUBBLE = 3'd0;
    localparam logic [KIND_W-1:0] KIND_MOVE   = 3'd1;
    localparam logic [KIND_W-1:0] KIND_ADD    = 3'd2;
    localparam logic [KIND_W-1:0] KIND_SUB    = 3'd3;
    localparam logic [KIND_W-1:0] KIND_CMP    = 3'd4;
    localparam logic [KIND_W-1:0] KIND_LOAD   = 3'd5;
    localparam logic [KIND_W-1:0] KIND_STORE  = 3'd6;
    localparam logic [KIND_W-1:0] KIND_BRANCH = 3'd7;

    typedef union packed {
        struct packed {
            logic [OPC_W-1:0]     opcode;
            logic                 imm_flag;
            logic [REG_SEL_W-1:0] rx;
            logic [IMM_W-1:0]     imm;         // signed
        } imm_form;
        struct packed {
            logic [OPC_W-1:0]           opcode;
            logic                       imm_flag;
            logic [REG_SEL_W-1:0]       rx;
            logic [IMM_W-REG_SEL_W-1:0] zero_field;
            logic [REG_SEL_W-1:0]       ry;
        } reg_form;
    } instr_word_t;

    // kinds that end in a register write
    function automatic logic writes_reg(input logic [KIND_W-1:0] kind);
        return kind inside {KIND_MOVE, KIND_ADD, KIND_SUB, KIND_LOAD};
    endfunction

endpackage

`default_nettype wire

/* stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one pipeline record between two stages
interface stage_if
    import cpu_pkg::*;
();

    logic [KIND_W-1:0]    kind;  // bubble when the slot is empty
    logic [REG_SEL_W-1:0] dest;
    logic [WORD_W-1:0]    a;     // rX value, also store data
    logic [WORD_W-1:0]    b;     // operand two, then result or address
    logic [COND_W-1:0]    cond;
    logic [WORD_W-1:0]    pc;

    modport src (
        output kind, dest, a, b, cond, pc
    );

    modport dst (
        input kind, dest, a, b, cond, pc
    );

endinterface

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import cpu_pkg::*;
(
    input  wire                Clock,
    input  wire                Reset,
    output logic [WORD_W-1:0]  instr_addr,
    input  wire  [WORD_W-1:0]  instr_data,
    input  wire                decode_hold,
    input  wire                mem_hold,
    input  wire                redirect_valid,
    input  wire  [WORD_W-1:0]  redirect_pc,
    output instr_word_t        fetched_word,
    output logic [WORD_W-1:0]  fetched_pc
);

    logic [WORD_W-1:0] pc;
    logic              hold;

    assign instr_addr = pc;  // instruction port is read in the same cycle
    assign hold       = decode_hold || mem_hold;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc           <= '0;
            fetched_word <= '0;
            fetched_pc   <= '0;
        end else if (redirect_valid) begin
            // branch resolved, drop the word fetched behind it
            pc           <= redirect_pc;
            fetched_word <= '0;
        end else if (!hold) begin
            pc           <= pc + 1'b1;
            fetched_word <= instr_data;
            fetched_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  wire                   Clock,
    input  wire                   Reset,
    input  wire instr_word_t      fetched_word,
    input  wire  [WORD_W-1:0]     fetched_pc,
    input  wire                   mem_hold,
    output logic [REG_SEL_W-1:0]  read_a_sel,
    output logic [REG_SEL_W-1:0]  read_b_sel,
    input  wire  [WORD_W-1:0]     read_a,
    input  wire  [WORD_W-1:0]     read_b,
    stage_if.dst                  m1,
    stage_if.dst                  m2,
    input  wire                   reg_write_enable,
    input  wire  [REG_SEL_W-1:0]  reg_write_sel,
    stage_if.src                  de,
    output logic                  decode_hold
);

    logic [KIND_W-1:0]    kind;
    logic [REG_SEL_W-1:0] rx;
    logic [REG_SEL_W-1:0] ry;
    logic [WORD_W-1:0]    imm_ext;
    logic                 uses_ry;  // operand two comes from rY
    logic                 reads_regs;
    logic                 de_hit;
    logic                 m1_hit;
    logic                 m2_hit;
    logic                 hazard;

    assign rx         = fetched_word.imm_form.rx;
    assign ry         = fetched_word.reg_form.ry;
    assign read_a_sel = rx;
    assign read_b_sel = ry;
    assign imm_ext    = {{(WORD_W-IMM_W){fetched_word.imm_form.imm[IMM_W-1]}},
                         fetched_word.imm_form.imm};

    always_comb begin
        case (fetched_word.imm_form.opcode)
            OPC_MV:  kind = KIND_MOVE;
            OPC_B:   kind = fetched_word.imm_form.imm_flag ? KIND_BUBBLE : KIND_BRANCH;  // mvt dropped
            OPC_ADD: kind = KIND_ADD;
            OPC_SUB: kind = KIND_SUB;
            OPC_LD:  kind = KIND_LOAD;
            OPC_ST:  kind = KIND_STORE;
            OPC_CMP: begin
                // register form is a compare only with a clear zero field
                if (fetched_word.imm_form.imm_flag || fetched_word.reg_form.zero_field == '0) begin
                    kind = KIND_CMP;
                end else begin
                    kind = KIND_BUBBLE;
                end
            end
            default: kind = KIND_BUBBLE;  // logic ops
        endcase
        if (fetched_word == '0) begin
            kind = KIND_BUBBLE;
        end
    end

    assign uses_ry    = !fetched_word.imm_form.imm_flag && kind != KIND_BRANCH;
    assign reads_regs = kind != KIND_BUBBLE && kind != KIND_BRANCH;

    // no forwarding, so any older writer of rX or rY blocks issue
    assign de_hit = writes_reg(de.kind) && (de.dest == rx || (uses_ry && de.dest == ry));
    assign m1_hit = writes_reg(m1.kind) && (m1.dest == rx || (uses_ry && m1.dest == ry));
    assign m2_hit = reg_write_enable && m2.kind != KIND_BUBBLE &&
                    (reg_write_sel == rx || (uses_ry && reg_write_sel == ry));

    assign hazard      = reads_regs && (de_hit || m1_hit || m2_hit);
    assign decode_hold = hazard || de.kind == KIND_BRANCH;  // branch waits for redirect

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            de.kind <= KIND_BUBBLE;
            de.dest <= '0;
            de.a    <= '0;
            de.b    <= '0;
            de.cond <= COND_NONE;
            de.pc   <= '0;
        end else if (!mem_hold) begin
            if (decode_hold) begin
                de.kind <= KIND_BUBBLE;
            end else begin
                de.kind <= kind;
                de.dest <= rx;
                de.a    <= read_a;
                de.b    <= uses_ry ? read_b : imm_ext;
                de.cond <= rx;  // same bits, meaningful for branches only
                de.pc   <= fetched_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import cpu_pkg::*;
(
    input  wire                   Clock,
    input  wire                   Reset,
    input  wire  [REG_SEL_W-1:0]  read_a_sel,
    input  wire  [REG_SEL_W-1:0]  read_b_sel,
    input  wire                   write_enable,
    input  wire  [REG_SEL_W-1:0]  write_sel,
    input  wire  [WORD_W-1:0]     write_value,
    output logic [WORD_W-1:0]     read_a,
    output logic [WORD_W-1:0]     read_b
);

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_sel] <= write_value;
        end
    end

    // reads see the old value on the write edge
    assign read_a = regs[read_a_sel];
    assign read_b = regs[read_b_sel];

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  wire                Clock,
    input  wire                Reset,
    input  wire                mem_hold,
    stage_if.dst               de,
    stage_if.src               m1,
    output logic               redirect_valid,
    output logic [WORD_W-1:0]  redirect_pc
);

    logic              flag_n;
    logic              flag_z;
    logic              flag_c;
    logic [WORD_W:0]   diff;    // borrow lands in the top bit
    logic [WORD_W-1:0] result;
    logic              taken;

    assign diff = {1'b0, de.a} - {1'b0, de.b};

    always_comb begin
        case (de.kind)
            KIND_ADD: result = de.a + de.b;
            KIND_SUB: result = diff[WORD_W-1:0];
            default:  result = de.b;  // move value or load/store address
        endcase
    end

    always_comb begin
        case (de.cond)
            COND_NONE: taken = 1'b1;
            COND_EQ:   taken = flag_z;
            COND_NE:   taken = !flag_z;
            COND_CC:   taken = !flag_c;
            COND_CS:   taken = flag_c;
            COND_PL:   taken = !flag_z && !flag_n;
            COND_MI:   taken = !flag_z && flag_n;
            default:   taken = 1'b1;
        endcase
    end

    // redirect on both outcomes, fetch has run one word past the branch
    assign redirect_valid = de.kind == KIND_BRANCH && !mem_hold;
    assign redirect_pc    = taken ? de.pc + 1'b1 + de.b : de.pc + 1'b1;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            flag_n  <= 1'b0;
            flag_z  <= 1'b0;
            flag_c  <= 1'b0;
            m1.kind <= KIND_BUBBLE;
            m1.dest <= '0;
            m1.a    <= '0;
            m1.b    <= '0;
            m1.cond <= COND_NONE;
            m1.pc   <= '0;
        end else if (!mem_hold) begin
            if (de.kind == KIND_CMP) begin
                flag_z <= diff[WORD_W-1:0] == '0;
                flag_n <= diff[WORD_W-1];
                flag_c <= diff[WORD_W];
            end
            m1.kind <= (de.kind == KIND_BRANCH) ? KIND_BUBBLE : de.kind;  // branch retires here
            m1.dest <= de.dest;
            m1.a    <= de.a;
            m1.b    <= result;
            m1.cond <= de.cond;
            m1.pc   <= de.pc;
        end
    end

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage
    import cpu_pkg::*;
(
    input  wire                   Clock,
    input  wire                   Reset,
    input  wire  [WORD_W-1:0]     data_rdata,
    input  wire                   data_done,
    stage_if.dst                  m1,
    output logic [WORD_W-1:0]     data_addr,
    output logic [WORD_W-1:0]     data_wdata,
    output logic                  data_read,
    output logic                  data_write,
    output logic                  mem_hold,
    stage_if.src                  m2,
    output logic                  reg_write_enable,
    output logic [REG_SEL_W-1:0]  reg_write_sel,
    output logic [WORD_W-1:0]     reg_write_value
);

    logic is_load;
    logic is_store;

    assign is_load  = m1.kind == KIND_LOAD;
    assign is_store = m1.kind == KIND_STORE;

    // port stays steady while m1 holds the access
    assign data_addr  = m1.b;
    assign data_wdata = m1.a;
    assign data_read  = is_load;
    assign data_write = is_store;
    assign mem_hold   = (is_load || is_store) && !data_done;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            m2.kind <= KIND_BUBBLE;
            m2.dest <= '0;
            m2.a    <= '0;
            m2.b    <= '0;
            m2.cond <= COND_NONE;
            m2.pc   <= '0;
        end else if (mem_hold) begin
            m2.kind <= KIND_BUBBLE;  // access still pending
        end else begin
            m2.kind <= m1.kind;
            m2.dest <= m1.dest;
            m2.a    <= m1.a;
            m2.b    <= is_load ? data_rdata : m1.b;
            m2.cond <= m1.cond;
            m2.pc   <= m1.pc;
        end
    end

    // write lands on the edge the record leaves m2
    assign reg_write_enable = writes_reg(m2.kind);
    assign reg_write_sel    = m2.dest;
    assign reg_write_value  = m2.b;

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  wire                Clock,
    input  wire                Reset,
    output logic [WORD_W-1:0]  instr_addr,
    input  wire  [WORD_W-1:0]  instr_data,
    output logic [WORD_W-1:0]  data_addr,
    output logic [WORD_W-1:0]  data_wdata,
    input  wire  [WORD_W-1:0]  data_rdata,
    input  wire                data_done,
    output logic               data_read,
    output logic               data_write
);

    instr_word_t          fetched_word;
    logic [WORD_W-1:0]    fetched_pc;
    logic                 decode_hold;
    logic                 mem_hold;
    logic                 redirect_valid;
    logic [WORD_W-1:0]    redirect_pc;
    logic [REG_SEL_W-1:0] read_a_sel;
    logic [REG_SEL_W-1:0] read_b_sel;
    logic [WORD_W-1:0]    read_a;
    logic [WORD_W-1:0]    read_b;
    logic                 reg_write_enable;
    logic [REG_SEL_W-1:0] reg_write_sel;
    logic [WORD_W-1:0]    reg_write_value;

    stage_if if_de ();  // decode to execute
    stage_if if_m1 ();  // execute to memory
    stage_if if_m2 ();  // memory record that writes back

    fetch_stage u_fetch (
        .Clock          (Clock),
        .Reset          (Reset),
        .instr_addr     (instr_addr),
        .instr_data     (instr_data),
        .decode_hold    (decode_hold),
        .mem_hold       (mem_hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetched_word   (fetched_word),
        .fetched_pc     (fetched_pc)
    );

    decode_stage u_decode (
        .Clock            (Clock),
        .Reset            (Reset),
        .fetched_word     (fetched_word),
        .fetched_pc       (fetched_pc),
        .mem_hold         (mem_hold),
        .read_a_sel       (read_a_sel),
        .read_b_sel       (read_b_sel),
        .read_a           (read_a),
        .read_b           (read_b),
        .m1               (if_m1),
        .m2               (if_m2),
        .reg_write_enable (reg_write_enable),
        .reg_write_sel    (reg_write_sel),
        .de               (if_de),
        .decode_hold      (decode_hold)
    );

    register_file u_regs (
        .Clock        (Clock),
        .Reset        (Reset),
        .read_a_sel   (read_a_sel),
        .read_b_sel   (read_b_sel),
        .write_enable (reg_write_enable),
        .write_sel    (reg_write_sel),
        .write_value  (reg_write_value),
        .read_a       (read_a),
        .read_b       (read_b)
    );

    execute_stage u_execute (
        .Clock          (Clock),
        .Reset          (Reset),
        .mem_hold       (mem_hold),
        .de             (if_de),
        .m1             (if_m1),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    memory_stage u_memory (
        .Clock            (Clock),
        .Reset            (Reset),
        .data_rdata       (data_rdata),
        .data_done        (data_done),
        .m1               (if_m1),
        .data_addr        (data_addr),
        .data_wdata       (data_wdata),
        .data_read        (data_read),
        .data_write       (data_write),
        .mem_hold         (mem_hold),
        .m2               (if_m2),
        .reg_write_enable (reg_write_enable),
        .reg_write_sel    (reg_write_sel),
        .reg_write_value  (reg_write_value)
    );

endmodule

`default_nettype wire

/* tb_isa_model.sv */
`timescale 1ns/1ps
`default_nettype none

// instruction-level model, one instruction per step, records every store in order
module tb_isa_model
    import cpu_pkg::*;
();

    localparam int MEM_DEPTH  = 256;
    localparam int MAX_STEPS  = 1000;
    localparam int MAX_STORES = 64;

    logic [WORD_W-1:0] rom       [MEM_DEPTH];
    logic [WORD_W-1:0] mem       [MEM_DEPTH];
    logic [WORD_W-1:0] exp_addr  [MAX_STORES];
    logic [WORD_W-1:0] exp_value [MAX_STORES];
    int                exp_count;
    logic              halted;  // reached the branch to itself

    task automatic load_instr(input int addr, input logic [WORD_W-1:0] word);
        rom[addr] = word;
    endtask

    task automatic load_data(input int addr, input logic [WORD_W-1:0] value);
        mem[addr] = value;
    endtask

    function automatic logic cond_holds(input logic [2:0] cond, input logic n, input logic z,
                                        input logic c);
        case (cond)
            COND_NONE: return 1'b1;
            COND_EQ:   return z;
            COND_NE:   return !z;
            COND_CC:   return !c;
            COND_CS:   return c;
            COND_PL:   return !z && !n;
            COND_MI:   return !z && n;
            default:   return 1'b0;
        endcase
    endfunction

    task automatic run();
        logic [WORD_W-1:0] regs [NUM_REGS];
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] next_pc;
        logic [WORD_W-1:0] word;
        logic [WORD_W-1:0] imm;
        logic [WORD_W-1:0] op2;
        logic [WORD_W-1:0] rxv;
        logic [WORD_W-1:0] diff;
        logic [2:0]        rx;
        logic              n;
        logic              z;
        logic              c;
        int                r;
        int                steps;
        for (r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        pc        = '0;
        n         = 1'b0;
        z         = 1'b0;
        c         = 1'b0;
        exp_count = 0;
        halted    = 1'b0;
        steps     = 0;
        while (!halted && steps < MAX_STEPS) begin
            word    = rom[pc[7:0]];
            rx      = word[11:9];
            rxv     = regs[rx];
            imm     = {{7{word[8]}}, word[8:0]};
            op2     = word[12] ? imm : regs[word[2:0]];
            next_pc = pc + 16'd1;
            case (word[15:13])
                OPC_MV:  regs[rx] = op2;
                OPC_ADD: regs[rx] = rxv + op2;
                OPC_SUB: regs[rx] = rxv - op2;
                OPC_CMP: begin
                    diff = rxv - op2;
                    z    = diff == 16'd0;
                    n    = diff[15];
                    c    = rxv < op2;  // borrow
                end
                OPC_LD:  regs[rx] = mem[op2[7:0]];
                OPC_ST: begin
                    mem[op2[7:0]]        = rxv;
                    exp_addr[exp_count]  = op2;
                    exp_value[exp_count] = rxv;
                    exp_count++;
                end
                OPC_B: begin
                    // immediate flag set here is the dropped move-top
                    if (!word[12] && cond_holds(rx, n, z, c)) begin
                        next_pc = pc + 16'd1 + imm;
                    end
                    halted = next_pc == pc;
                end
                default: ;  // logic ops act as no-ops
            endcase
            pc = next_pc;
            steps++;
        end
    endtask

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int MEM_DEPTH    = 256;
    localparam int DRAIN_CYCLES = 40;  // idle time at the final branch

    logic              Clock;
    logic              Reset;
    logic [WORD_W-1:0] instr_addr;
    logic [WORD_W-1:0] instr_data;
    logic [WORD_W-1:0] data_addr;
    logic [WORD_W-1:0] data_wdata;
    logic [WORD_W-1:0] data_rdata;
    logic              data_done;
    logic              data_read;
    logic              data_write;

    logic [WORD_W-1:0] rom      [MEM_DEPTH];
    logic [WORD_W-1:0] data_mem [MEM_DEPTH];
    int                prog_len;
    int                stores_seen;
    int                idx;
    integer            seed;
    logic              in_access;
    int                cycles_left;
    logic [WORD_W-1:0] held_addr;
    logic [WORD_W-1:0] held_wdata;
    logic [1:0]        held_strobes;

    cpu_top dut (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_done  (data_done),
        .data_read  (data_read),
        .data_write (data_write)
    );

    tb_isa_model model ();

    assign instr_data = rom[instr_addr[7:0]];  // combinational ROM

    initial Clock = 1'b0;
    always #4 Clock = ~Clock;

    task automatic stop_on_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        stop_on_failure();
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [WORD_W-1:0] expected,
                                   input logic [WORD_W-1:0] actual);
        $display("CHECK FAILED test=%s %s expected=%h actual=%h", test, what, expected, actual);
        stop_on_failure();
    endtask

    function automatic string test_name(input logic [WORD_W-1:0] addr);
        if (addr >= 16'h60) begin
            return "branch";
        end else if (addr >= 16'h50 || addr < 16'h40) begin
            return "load";
        end else begin
            return "arith";
        end
    endfunction

    // instruction encoders following the word layout
    function automatic logic [WORD_W-1:0] imm_word(input logic [2:0] opc, input logic [2:0] rx,
                                                   input int imm);
        return {opc, 1'b1, rx, imm[8:0]};
    endfunction

    function automatic logic [WORD_W-1:0] reg_word(input logic [2:0] opc, input logic [2:0] rx,
                                                   input logic [2:0] ry);
        return {opc, 1'b0, rx, 6'b0, ry};
    endfunction

    function automatic logic [WORD_W-1:0] branch_word(input logic [2:0] cond, input int imm);
        return {OPC_B, 1'b0, cond, imm[8:0]};
    endfunction

    function automatic logic [WORD_W-1:0] fill_value(input int addr);
        return 16'(addr * 16'h0457 + 16'h3c5a);  // odd multiplier so every address bit counts
    endfunction

    task automatic put(input logic [WORD_W-1:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_program();
        // arithmetic in both operand forms with mostly back-to-back dependences
        put(imm_word(OPC_MV, 3'd1, 100));
        put(imm_word(OPC_MV, 3'd2, -3));
        put(imm_word(OPC_ADD, 3'd1, 25));      // r1 = 125
        put(reg_word(OPC_SUB, 3'd2, 3'd1));    // r2 = -128
        put(reg_word(OPC_MV, 3'd3, 3'd2));
        put(imm_word(OPC_SUB, 3'd3, -200));    // r3 = 72
        put(reg_word(OPC_ADD, 3'd3, 3'd1));
        put(imm_word(OPC_ST, 3'd1, 'h40));
        put(imm_word(OPC_ST, 3'd2, 'h41));
        put(imm_word(OPC_ST, 3'd3, 'h42));
        put(imm_word(OPC_MV, 3'd7, 255));
        put(reg_word(OPC_ADD, 3'd7, 3'd7));    // r7 is an ordinary register
        put(reg_word(OPC_SUB, 3'd7, 3'd2));
        put(imm_word(OPC_ST, 3'd7, 'h43));
        // loads
        put(imm_word(OPC_LD, 3'd4, 'h10));
        put(imm_word(OPC_LD, 3'd5, -2));       // address 0xfffe
        put(reg_word(OPC_SUB, 3'd4, 3'd5));
        put(imm_word(OPC_ST, 3'd4, 'h50));
        put(imm_word(OPC_ST, 3'd1, 'h20));
        put(imm_word(OPC_LD, 3'd6, 'h20));     // reads back the store
        put(imm_word(OPC_MV, 3'd0, 'h11));
        put(reg_word(OPC_LD, 3'd5, 3'd0));
        put(imm_word(OPC_ST, 3'd6, 'h51));
        put(imm_word(OPC_ST, 3'd5, 'h52));
        // compare followed by each condition taken and not taken
        put(imm_word(OPC_MV, 3'd1, 5));
        put(imm_word(OPC_MV, 3'd2, 9));
        put(imm_word(OPC_MV, 3'd3, 5));
        put(reg_word(OPC_CMP, 3'd1, 3'd3));    // equal
        put(branch_word(COND_EQ, 1));
        put(imm_word(OPC_ST, 3'd2, 'h60));
        put(branch_word(COND_NE, 1));
        put(imm_word(OPC_ST, 3'd1, 'h61));
        put(reg_word(OPC_CMP, 3'd1, 3'd2));    // negative with borrow
        put(branch_word(COND_CS, 1));
        put(imm_word(OPC_ST, 3'd1, 'h62));
        put(branch_word(COND_CC, 1));
        put(imm_word(OPC_ST, 3'd2, 'h63));
        put(branch_word(COND_MI, 1));
        put(imm_word(OPC_ST, 3'd1, 'h64));
        put(branch_word(COND_PL, 1));
        put(imm_word(OPC_ST, 3'd3, 'h65));
        put(imm_word(OPC_CMP, 3'd2, 5));       // positive without borrow
        put(branch_word(COND_PL, 1));
        put(imm_word(OPC_ST, 3'd1, 'h66));
        put(branch_word(COND_MI, 1));
        put(imm_word(OPC_ST, 3'd2, 'h67));
        put(branch_word(COND_CC, 1));
        put(imm_word(OPC_ST, 3'd3, 'h68));
        put(branch_word(COND_CS, 1));
        put(imm_word(OPC_ST, 3'd1, 'h69));
        put(branch_word(COND_EQ, 1));
        put(imm_word(OPC_ST, 3'd2, 'h6a));
        put(branch_word(COND_NE, 1));
        put(imm_word(OPC_ST, 3'd3, 'h6b));
        put(branch_word(COND_NONE, 2));
        put(imm_word(OPC_ST, 3'd1, 'h6c));
        put(imm_word(OPC_ST, 3'd2, 'h6d));
        put(imm_word(OPC_ST, 3'd3, 'h6e));
        put(branch_word(COND_NONE, -1));       // parks here
    endtask

    // a store is compared with the next model entry in the cycle it completes
    task automatic check_store();
        assert (stores_seen < model.exp_count) else begin
            abort_run("the DUT stored more words than the model");
        end
        assert (data_addr == model.exp_addr[stores_seen]) else begin
            report_mismatch(test_name(model.exp_addr[stores_seen]), "store address",
                            model.exp_addr[stores_seen], data_addr);
        end
        assert (data_wdata == model.exp_value[stores_seen]) else begin
            report_mismatch(test_name(model.exp_addr[stores_seen]), "store data",
                            model.exp_value[stores_seen], data_wdata);
        end
        data_mem[data_addr[7:0]] = data_wdata;
        stores_seen++;
    endtask

    // data memory where each access takes 1 to 4 cycles
    always @(posedge Clock) begin
        #1;
        if (Reset) begin
            data_done = 1'b0;
            in_access = 1'b0;
        end else begin
            if (data_done) begin
                in_access = 1'b0;  // finished on this edge
                data_done = 1'b0;
            end
            if (data_read || data_write) begin
                if (!in_access) begin
                    in_access    = 1'b1;
                    cycles_left  = 1 + ($unsigned($random(seed)) % 4);
                    held_addr    = data_addr;
                    held_wdata   = data_wdata;
                    held_strobes = {data_read, data_write};
                end else begin
                    cycles_left--;
                    assert (data_addr == held_addr) else begin
                        report_mismatch("port_hold", "data_addr", held_addr, data_addr);
                    end
                    assert (data_wdata == held_wdata) else begin
                        report_mismatch("port_hold", "data_wdata", held_wdata, data_wdata);
                    end
                    assert ({data_read, data_write} == held_strobes) else begin
                        report_mismatch("port_hold", "strobes", {14'b0, held_strobes},
                                        {14'b0, data_read, data_write});
                    end
                end
                if (cycles_left == 1) begin
                    data_done = 1'b1;
                    if (data_read) begin
                        data_rdata = data_mem[data_addr[7:0]];
                    end else begin
                        check_store();
                    end
                end
            end else begin
                assert (!in_access) else begin
                    abort_run("a strobe dropped before data_done");
                end
            end
        end
    end

    initial begin
        seed        = 32'hf6ed_9e28;
        Reset       = 1'b1;
        data_done   = 1'b0;
        data_rdata  = '0;
        in_access   = 1'b0;
        cycles_left = 0;
        stores_seen = 0;
        prog_len    = 0;
        for (idx = 0; idx < MEM_DEPTH; idx++) begin
            rom[idx]      = '0;  // no-op fill
            data_mem[idx] = fill_value(idx);
            model.load_data(idx, data_mem[idx]);
        end
        load_program();
        for (idx = 0; idx < prog_len; idx++) begin
            model.load_instr(idx, rom[idx]);
        end
        model.run();
        assert (model.halted && model.exp_count > 0) else begin
            abort_run("the model did not reach the final branch");
        end
        repeat (3) @(posedge Clock);
        #1;
        assert (instr_addr == '0) else begin
            report_mismatch("reset", "instr_addr", 16'h0, instr_addr);
        end
        assert (!data_read && !data_write) else begin
            report_mismatch("reset", "strobes", 16'h0, {14'b0, data_read, data_write});
        end
        Reset = 1'b0;
        wait (stores_seen == model.exp_count);
        repeat (DRAIN_CYCLES) @(posedge Clock);
        $display("sim passed");
        $finish;
    end

    // watchdog allows twenty cycles per program word
    initial begin
        #1;
        repeat (prog_len * 20) @(posedge Clock);
        abort_run("watchdog timeout, the program did not finish its stores");
    end

endmodule

`default_nettype wire

/* vlog.f */
cpu_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_isa_model.sv
tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f vlog.f -o tb_cpu

output=$(./obj_dir/tb_cpu 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
